// File: brisc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module brisc_mem_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_start,
  input  brisc_pkg::addr_t        fetch_pc,
  input  brisc_pkg::fetch_count_t fetch_count,
  output logic                    fetch_busy,
  output logic                    instr_valid,
  output brisc_pkg::addr_t        instr_addr,
  output brisc_pkg::word_t        instr,
  input  logic                    load_req,
  input  brisc_pkg::addr_t        load_addr,
  output logic                    load_busy,
  output logic                    load_valid,
  output brisc_pkg::word_t        load_data
);

  // fetch side of the arbiter
  logic             fu_req;
  brisc_pkg::addr_t fu_req_addr;
  logic             fu_gnt;
  logic             fu_resp;

  // load side of the arbiter
  logic             lu_req;
  brisc_pkg::addr_t lu_req_addr;
  logic             lu_gnt;
  logic             lu_resp;

  // shared response word
  brisc_pkg::word_t resp_data;

  // ram port
  logic             mem_req;
  brisc_pkg::addr_t mem_addr;
  logic             mem_resp;
  brisc_pkg::word_t mem_data;

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .fetch_start(fetch_start),
    .fetch_pc   (fetch_pc),
    .fetch_count(fetch_count),
    .fetch_busy (fetch_busy),
    .instr_valid(instr_valid),
    .instr_addr (instr_addr),
    .instr      (instr),
    .req        (fu_req),
    .req_addr   (fu_req_addr),
    .gnt        (fu_gnt),
    .resp       (fu_resp),
    .resp_data  (resp_data)
  );

  load_unit u_load (
    .clk       (clk),
    .rst       (rst),
    .load_req  (load_req),
    .load_addr (load_addr),
    .load_busy (load_busy),
    .load_valid(load_valid),
    .load_data (load_data),
    .req       (lu_req),
    .req_addr  (lu_req_addr),
    .gnt       (lu_gnt),
    .resp      (lu_resp),
    .resp_data (resp_data)
  );

  mem_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fu_req),
    .fetch_addr(fu_req_addr),
    .fetch_gnt (fu_gnt),
    .fetch_resp(fu_resp),
    .load_req  (lu_req),
    .load_addr (lu_req_addr),
    .load_gnt  (lu_gnt),
    .load_resp (lu_resp),
    .resp_data (resp_data),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_resp  (mem_resp),
    .mem_data  (mem_data)
  );

  ram u_ram (
    .clk (clk),
    .rst (rst),
    .req (mem_req),
    .addr(mem_addr),
    .resp(mem_resp),
    .data(mem_data)
  );

endmodule

`default_nettype wire

// File: brisc_pkg.sv
`default_nettype none
`include "brisc_settings.svh"

package brisc_pkg;

  // byte address from the core
  typedef logic [`BRISC_ADDRESS_BITS-1:0] addr_t;

  // one data or instruction word
  typedef logic [31:0] word_t;

  // number of words in one fetch run
  typedef logic [`BRISC_FETCH_COUNT_BITS-1:0] fetch_count_t;

  // fetch fsm
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_t;

endpackage

`default_nettype wire

// File: brisc_settings.svh
`ifndef BRISC_SETTINGS_SVH
`define BRISC_SETTINGS_SVH

// byte address width seen by the core
`define BRISC_ADDRESS_BITS 32

// ram depth in 32-bit words
`define BRISC_MEM_WORDS 64

// cycles from ram request to array read
`define BRISC_MEM_REQ_DELAY 5

// cycles from array read to ram response
`define BRISC_MEM_RESP_DELAY 5

// width of the fetch run length
`define BRISC_FETCH_COUNT_BITS 8

`endif

// File: build.f
+incdir+.
brisc_pkg.sv
mem_pkg.sv
delay_line.sv
ram.sv
mem_arbiter.sv
fetch_unit.sv
load_unit.sv
brisc_mem_top.sv
tb_brisc_mem.sv

// File: delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 5
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data
);

  // one valid bit and one data slot per stage
  logic [DEPTH-1:0] valid_q;
  logic [WIDTH-1:0] data_q [DEPTH];

  // valid chain, shifts every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // data rides alongside valid
  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  // last stage is the output
  assign out_valid = valid_q[DEPTH-1];
  assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_start,
  input  brisc_pkg::addr_t        fetch_pc,
  input  brisc_pkg::fetch_count_t fetch_count,
  output logic                    fetch_busy,
  output logic                    instr_valid,
  output brisc_pkg::addr_t        instr_addr,
  output brisc_pkg::word_t        instr,
  output logic                    req,
  output brisc_pkg::addr_t        req_addr,
  input  logic                    gnt,
  input  logic                    resp,
  input  brisc_pkg::word_t        resp_data
);

  brisc_pkg::fetch_state_t state_q;

  // address of the word in flight
  brisc_pkg::addr_t        pc_q;
  // words still to return, this one included
  brisc_pkg::fetch_count_t left_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= brisc_pkg::FETCH_IDLE;
    end else begin
      case (state_q)
        brisc_pkg::FETCH_IDLE: begin
          // zero count starts nothing
          if (fetch_start && fetch_count != '0) begin
            state_q <= brisc_pkg::FETCH_REQ;
          end
        end
        brisc_pkg::FETCH_REQ: begin
          if (gnt) begin
            state_q <= brisc_pkg::FETCH_WAIT;
          end
        end
        brisc_pkg::FETCH_WAIT: begin
          if (resp) begin
            state_q <= (left_q == 'd1) ? brisc_pkg::FETCH_IDLE : brisc_pkg::FETCH_REQ;
          end
        end
        default: state_q <= brisc_pkg::FETCH_IDLE;
      endcase
    end
  end

  // run position, loaded on start and stepped per word
  always_ff @(posedge clk) begin
    if (state_q == brisc_pkg::FETCH_IDLE && fetch_start) begin
      pc_q   <= fetch_pc;
      left_q <= fetch_count;
    end else if (state_q == brisc_pkg::FETCH_WAIT && resp) begin
      pc_q   <= pc_q + 'd4;
      left_q <= left_q - 'd1;
    end
  end

  assign fetch_busy = (state_q != brisc_pkg::FETCH_IDLE);
  assign req        = (state_q == brisc_pkg::FETCH_REQ);
  assign req_addr   = pc_q;

  // returned word leaves in its arrival cycle
  assign instr_valid = resp;
  assign instr_addr  = pc_q;
  assign instr       = resp_data;

endmodule

`default_nettype wire

// File: load_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             load_req,
  input  brisc_pkg::addr_t load_addr,
  output logic             load_busy,
  output logic             load_valid,
  output brisc_pkg::word_t load_data,
  output logic             req,
  output brisc_pkg::addr_t req_addr,
  input  logic             gnt,
  input  logic             resp,
  input  brisc_pkg::word_t resp_data
);

  // busy covers request and wait
  always_ff @(posedge clk) begin
    if (rst) begin
      load_busy <= 1'b0;
      req       <= 1'b0;
    end else if (!load_busy) begin
      if (load_req) begin
        load_busy <= 1'b1;
        req       <= 1'b1;
      end
    end else begin
      // drop the request once granted
      if (gnt) begin
        req <= 1'b0;
      end
      if (resp) begin
        load_busy <= 1'b0;
      end
    end
  end

  // new load ignored while busy
  always_ff @(posedge clk) begin
    if (!load_busy && load_req) begin
      req_addr <= load_addr;
    end
  end

  // response passes out in the same cycle
  assign load_valid = resp;
  assign load_data  = resp_data;

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetch_req,
  input  brisc_pkg::addr_t fetch_addr,
  output logic             fetch_gnt,
  output logic             fetch_resp,
  input  logic             load_req,
  input  brisc_pkg::addr_t load_addr,
  output logic             load_gnt,
  output logic             load_resp,
  output brisc_pkg::word_t resp_data,
  output logic             mem_req,
  output brisc_pkg::addr_t mem_addr,
  input  logic             mem_resp,
  input  brisc_pkg::word_t mem_data
);

  mem_pkg::arb_state_t last_q;

  // peer still requesting in its grant cycle is not eligible again
  logic fetch_elig;
  logic load_elig;
  logic pick_fetch;
  logic pick_load;
  logic push;
  logic pop;
  mem_pkg::requester_t push_owner;

  // owner queue, entry 0 is the head
  mem_pkg::requester_t owner_q [2];
  logic [1:0] count_q;

  assign fetch_elig = fetch_req && !fetch_gnt;
  assign load_elig  = load_req && !load_gnt;

  // on a tie the peer not served last wins
  always_comb begin
    if (fetch_elig && load_elig) begin
      pick_fetch = (last_q == mem_pkg::ARB_LAST_LOAD);
      pick_load  = (last_q == mem_pkg::ARB_LAST_FETCH);
    end else begin
      pick_fetch = fetch_elig;
      pick_load  = load_elig;
    end
  end

  assign push       = pick_fetch || pick_load;
  assign pop        = mem_resp;
  assign push_owner = pick_load ? mem_pkg::REQ_LOAD : mem_pkg::REQ_FETCH;

  // grant and ram request registered together
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_gnt <= 1'b0;
      load_gnt  <= 1'b0;
      mem_req   <= 1'b0;
      last_q    <= mem_pkg::ARB_LAST_LOAD;
    end else begin
      fetch_gnt <= pick_fetch;
      load_gnt  <= pick_load;
      mem_req   <= push;
      if (pick_fetch) begin
        last_q <= mem_pkg::ARB_LAST_FETCH;
      end else if (pick_load) begin
        last_q <= mem_pkg::ARB_LAST_LOAD;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_addr <= pick_load ? load_addr : fetch_addr;
    end
  end

  // queue occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (push && !pop) begin
      count_q <= count_q + 2'd1;
    end else if (pop && !push) begin
      count_q <= count_q - 2'd1;
    end
  end

  // queue entries, shift toward the head on pop
  always_ff @(posedge clk) begin
    if (pop) begin
      owner_q[0] <= owner_q[1];
    end
    if (push) begin
      if (pop) begin
        // one slot freed this cycle
        if (count_q == 2'd1) begin
          owner_q[0] <= push_owner;
        end else begin
          owner_q[1] <= push_owner;
        end
      end else if (count_q == 2'd0) begin
        owner_q[0] <= push_owner;
      end else begin
        owner_q[1] <= push_owner;
      end
    end
  end

  // response steered by the head owner
  assign fetch_resp = mem_resp && (owner_q[0] == mem_pkg::REQ_FETCH);
  assign load_resp  = mem_resp && (owner_q[0] == mem_pkg::REQ_LOAD);
  assign resp_data  = mem_data;

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none
`include "brisc_settings.svh"

package mem_pkg;

  // ram word index, address bits 7:2 for 64 words
  typedef logic [$clog2(`BRISC_MEM_WORDS)-1:0] word_index_t;

  // owner of an in-flight ram request
  typedef enum logic {
    REQ_FETCH,
    REQ_LOAD
  } requester_t;

  // last peer granted, for round robin
  typedef enum logic {
    ARB_LAST_FETCH,
    ARB_LAST_LOAD
  } arb_state_t;

endpackage

`default_nettype wire

// File: ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "brisc_settings.svh"

module ram (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  input  brisc_pkg::addr_t addr,
  output logic             resp,
  output brisc_pkg::word_t data
);

  localparam int INDEX_BITS = $bits(mem_pkg::word_index_t);
  localparam int WORD_BITS  = $bits(brisc_pkg::word_t);

  // word array, contents from ram.txt
  brisc_pkg::word_t mem_array [`BRISC_MEM_WORDS];

  // word index straight from the byte address
  mem_pkg::word_index_t req_index;

  // request line output
  logic                 read_valid;
  mem_pkg::word_index_t read_index;

  // array output into the response line
  brisc_pkg::word_t     read_word;

  initial begin
    $readmemh("ram.txt", mem_array);
  end

  // byte offset dropped, upper bits ignored
  assign req_index = addr[INDEX_BITS+1:2];

  // request delay, carries only the index
  delay_line #(
    .WIDTH(INDEX_BITS),
    .DEPTH(`BRISC_MEM_REQ_DELAY)
  ) u_req_line (
    .clk      (clk),
    .rst      (rst),
    .in_valid (req),
    .in_data  (req_index),
    .out_valid(read_valid),
    .out_data (read_index)
  );

  // array read between the two lines
  assign read_word = mem_array[read_index];

  // response delay with the read word
  delay_line #(
    .WIDTH(WORD_BITS),
    .DEPTH(`BRISC_MEM_RESP_DELAY)
  ) u_resp_line (
    .clk      (clk),
    .rst      (rst),
    .in_valid (read_valid),
    .in_data  (read_word),
    .out_valid(resp),
    .out_data (data)
  );

endmodule

`default_nettype wire

// File: ram.txt
// one 32-bit hex word per line
// line i holds ram word index i, value c0de0000 plus 4*i
c0de0000
c0de0004
c0de0008
c0de000c
c0de0010
c0de0014
c0de0018
c0de001c
c0de0020
c0de0024
c0de0028
c0de002c
c0de0030
c0de0034
c0de0038
c0de003c
c0de0040
c0de0044
c0de0048
c0de004c
c0de0050
c0de0054
c0de0058
c0de005c
c0de0060
c0de0064
c0de0068
c0de006c
c0de0070
c0de0074
c0de0078
c0de007c
c0de0080
c0de0084
c0de0088
c0de008c
c0de0090
c0de0094
c0de0098
c0de009c
c0de00a0
c0de00a4
c0de00a8
c0de00ac
c0de00b0
c0de00b4
c0de00b8
c0de00bc
c0de00c0
c0de00c4
c0de00c8
c0de00cc
c0de00d0
c0de00d4
c0de00d8
c0de00dc
c0de00e0
c0de00e4
c0de00e8
c0de00ec
c0de00f0
c0de00f4
c0de00f8
c0de00fc

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the brisc memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  -f build.f --top-module tb_brisc_mem -o sim_brisc_mem

# ram.txt is read relative to the project root
./obj_dir/sim_brisc_mem

// File: tb_brisc_mem.sv
`timescale 1ns/1ns
`default_nettype none
`include "brisc_settings.svh"

module tb_brisc_mem;

  // load unit cycle, grant cycle, then the ram
  localparam int LOAD_LATENCY = 2 + `BRISC_MEM_REQ_DELAY + `BRISC_MEM_RESP_DELAY;
  localparam int WAIT_LIMIT   = 2000;

  logic                    clk;
  logic                    rst;
  logic                    fetch_start;
  brisc_pkg::addr_t        fetch_pc;
  brisc_pkg::fetch_count_t fetch_count;
  logic                    fetch_busy;
  logic                    instr_valid;
  brisc_pkg::addr_t        instr_addr;
  brisc_pkg::word_t        instr;
  logic                    load_req;
  brisc_pkg::addr_t        load_addr;
  logic                    load_busy;
  logic                    load_valid;
  brisc_pkg::word_t        load_data;

  int seed;
  // scoreboard state
  brisc_pkg::addr_t next_fetch_addr;
  brisc_pkg::addr_t load_queue [$];
  int               instr_seen;
  int               instr_expected;
  int               loads_seen;
  int               loads_issued;

  brisc_mem_top dut (
    .clk        (clk),
    .rst        (rst),
    .fetch_start(fetch_start),
    .fetch_pc   (fetch_pc),
    .fetch_count(fetch_count),
    .fetch_busy (fetch_busy),
    .instr_valid(instr_valid),
    .instr_addr (instr_addr),
    .instr      (instr),
    .load_req   (load_req),
    .load_addr  (load_addr),
    .load_busy  (load_busy),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ram rule, only address bits 7:2 select the word
  function automatic brisc_pkg::word_t expected_word(input brisc_pkg::addr_t addr);
    return 32'hC0DE_0000 + (addr & 32'h0000_00FC);
  endfunction

  task automatic abort_run(input string reason);
    $display("Some tests failed");
    $fatal(1, "%s", reason);
  endtask

  // all waits start and end 1 ns after a rising edge
  task automatic wait_load_idle();
    int cycles;
    cycles = 0;
    while (load_busy) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout: load_valid never arrived and load_busy stayed high");
        abort_run("load wait timed out");
      end
    end
  endtask

  task automatic wait_fetch_done();
    int cycles;
    cycles = 0;
    while (fetch_busy) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT * 4) begin
        $display("timeout: instr_valid pulses missing and fetch_busy never fell");
        abort_run("fetch wait timed out");
      end
    end
  endtask

  task automatic issue_load(input brisc_pkg::addr_t addr);
    wait_load_idle();
    load_req  = 1'b1;
    load_addr = addr;
    load_queue.push_back(addr);
    loads_issued++;
    @(posedge clk);
    #1;
    load_req = 1'b0;
  endtask

  task automatic start_fetch(input brisc_pkg::addr_t pc, input brisc_pkg::fetch_count_t count);
    wait_fetch_done();
    next_fetch_addr = pc;
    instr_expected  = instr_expected + int'(count);
    fetch_start     = 1'b1;
    fetch_pc        = pc;
    fetch_count     = count;
    @(posedge clk);
    #1;
    fetch_start = 1'b0;
  endtask

  // fetch words must come in order with the rule value
  always @(negedge clk) begin
    if (!rst && instr_valid) begin
      assert (instr_seen < instr_expected) else begin
        $display("FAIL at %0t ns: instr_valid pulse with no fetch word pending", $time);
        abort_run("unexpected instr_valid");
      end
      assert (instr_addr == next_fetch_addr && instr == expected_word(next_fetch_addr)) else begin
        $display("FAIL at %0t ns: fetch got addr %h word %h, expected addr %h word %h",
                 $time, instr_addr, instr, next_fetch_addr, expected_word(next_fetch_addr));
        abort_run("fetch word mismatch");
      end
      next_fetch_addr = next_fetch_addr + 32'd4;
      instr_seen++;
    end
  end

  // one load outstanding, so the queue head owns each pulse
  always @(negedge clk) begin : load_monitor
    brisc_pkg::addr_t want_addr;
    if (!rst && load_valid) begin
      assert (load_queue.size() > 0) else begin
        $display("FAIL at %0t ns: load_valid pulse with no load pending", $time);
        abort_run("unexpected load_valid");
      end
      want_addr = load_queue.pop_front();
      assert (load_data == expected_word(want_addr)) else begin
        $display("FAIL at %0t ns: load from %h returned %h, expected %h",
                 $time, want_addr, load_data, expected_word(want_addr));
        abort_run("load data mismatch");
      end
      loads_seen++;
    end
  end

  initial begin
    brisc_pkg::addr_t addr;
    int               cycles;
    int               gap;
    logic             got;
    seed           = 77;
    rst            = 1'b1;
    fetch_start    = 1'b0;
    fetch_pc       = '0;
    fetch_count    = '0;
    load_req       = 1'b0;
    load_addr      = '0;
    instr_seen     = 0;
    instr_expected = 0;
    loads_seen     = 0;
    loads_issued   = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet outputs after reset
    assert (!fetch_busy && !load_busy && !instr_valid && !load_valid) else begin
      $display("FAIL at %0t ns: busy or valid high after reset", $time);
      abort_run("reset state wrong");
    end

    // uncontended load latency
    addr      = $random(seed);
    load_req  = 1'b1;
    load_addr = addr;
    load_queue.push_back(addr);
    loads_issued++;
    cycles = 0;
    got    = 1'b0;
    while (!got) begin
      @(posedge clk);
      cycles++;
      #1 load_req = 1'b0;
      @(negedge clk);
      got = load_valid;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout: load_valid never arrived for the latency load");
        abort_run("latency wait timed out");
      end
    end
    assert (cycles == LOAD_LATENCY) else begin
      $display("FAIL at %0t ns: load latency %0d cycles, expected %0d",
               $time, cycles, LOAD_LATENCY);
      abort_run("load latency wrong");
    end
    @(posedge clk);
    #1;

    // zero count starts nothing
    start_fetch(32'h0000_0100, 8'd0);
    assert (!fetch_busy) else begin
      $display("FAIL at %0t ns: fetch_busy high after a zero count start", $time);
      abort_run("zero count fetch started");
    end

    // random run from a random start
    start_fetch($random(seed) & 32'hFFFF_FFFC, 8'd1 + 8'($random(seed) & 15));
    wait_fetch_done();

    // loads racing a long fetch
    start_fetch(32'h0000_0040, 8'd40);
    for (int i = 0; i < 10; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      issue_load($random(seed));
    end
    assert (fetch_busy) else begin
      $display("FAIL at %0t ns: fetch ended before the loads overlapped it", $time);
      abort_run("no contention");
    end
    wait_load_idle();
    wait_fetch_done();

    // upper and low address bits are ignored
    issue_load(32'h1234_5F07);
    issue_load(32'hFFFF_FF03);
    issue_load(32'h8000_0101);
    start_fetch(32'hFFFF_FFF2, 8'd4);
    wait_load_idle();
    wait_fetch_done();

    if (instr_seen == instr_expected && loads_seen == loads_issued
        && load_queue.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("FAIL at %0t ns: %0d of %0d words, %0d of %0d loads returned",
               $time, instr_seen, instr_expected, loads_seen, loads_issued);
      abort_run("pulse count mismatch");
    end
  end

endmodule

`default_nettype wire
